//--- tb.f
scan_pkg.sv
rcpt_dfa.sv
scan_config.sv
stream_context.sv
smtp_scan_top.sv
smtp_scan_assertions.sv
tb_smtp_scan.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the SMTP scanner testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --assert --top-module tb_smtp_scan -f tb.f

sim_status=0
./obj_dir/Vtb_smtp_scan > sim.log 2>&1 || sim_status=$?
cat sim.log

if [ "$sim_status" -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if grep -q "ERRORS FOUND" sim.log; then
   exit 1
fi

exit 0

//--- tb_smtp_scan.sv
`default_nettype none
`timescale 1ns/10ps

module tb_smtp_scan
   import scan_pkg::*;
();

   localparam int CLK_PERIOD = 100;
   localparam int MAX_ROWS   = 32;
   localparam int MAX_BYTES  = 16;

   // DUT inputs
   logic       clk;
   logic       rst_n;
   logic       load_state;
   stream_id_t stream_id;
   logic       eop;
   byte_t      char_in;
   logic       char_in_vld;
   logic       cfg_wr;
   stream_id_t cfg_stream;
   logic       cfg_enable;

   // DUT outputs
   logic       fired;
   count_t     count;

   // Stimulus table
   // One packet per row
   logic       row_cfg_wr     [MAX_ROWS];
   stream_id_t row_cfg_stream [MAX_ROWS];
   logic       row_cfg_enable [MAX_ROWS];
   stream_id_t row_stream     [MAX_ROWS];
   byte_t      row_payload    [MAX_ROWS][MAX_BYTES];
   int         row_len        [MAX_ROWS];
   logic       row_fired      [MAX_ROWS];
   int         num_rows;

   // Reference model of the scanner
   int         model_state  [NUM_STREAMS];
   logic       model_seen   [NUM_STREAMS];
   logic       model_enable [NUM_STREAMS];
   int         model_count;

   int         error_count;
   int         tests_run;

   smtp_scan_top smtp_scan_top_i
   (
      .clk         (clk),
      .rst_n       (rst_n),
      .load_state  (load_state),
      .stream_id   (stream_id),
      .eop         (eop),
      .char_in     (char_in),
      .char_in_vld (char_in_vld),
      .cfg_wr      (cfg_wr),
      .cfg_stream  (cfg_stream),
      .cfg_enable  (cfg_enable),
      .fired       (fired),
      .count       (count)
   );

   // Free-running clock
   initial
   begin
      clk = 1'b0;
      forever
      begin
         #(CLK_PERIOD/2) clk = ~clk;
      end
   end

   // Next-state rule of the matcher
   // A result of 8 means the pattern just completed
   function automatic int next_match_state(input int st, input byte_t ch);
      string pat;
      pat = "RCPT TO:";
      if (ch == pat[st])
         return st + 1;
      // A stray R restarts the attempt because R occurs once in the pattern
      else if (ch == "R")
         return 1;
      else
         return 0;
   endfunction

   task automatic add_row(input logic wr, input int wr_stream, input logic wr_enable,
                          input int stream, input string text, input logic exp_fired);
      begin
         row_cfg_wr[num_rows]     = wr;
         row_cfg_stream[num_rows] = stream_id_t'(wr_stream);
         row_cfg_enable[num_rows] = wr_enable;
         row_stream[num_rows]     = stream_id_t'(stream);
         row_len[num_rows]        = text.len();
         for (int i = 0; i < text.len(); i++)
            row_payload[num_rows][i] = text[i];
         row_fired[num_rows]      = exp_fired;
         num_rows++;
      end
   endtask

   task automatic build_table();
      begin
         // Fresh reset with stream 1 still disabled
         add_row(1'b0, 0, 1'b0, 1, "RCPT TO:", 1'b1);
         // Single and double match on an enabled stream
         add_row(1'b1, 1, 1'b1, 1, "xRCPT TO:y", 1'b1);
         add_row(1'b0, 0, 1'b0, 1, "RCPT TO:RCPT TO:", 1'b1);
         // Split match with stream 3 interleaved
         add_row(1'b1, 2, 1'b1, 2, "abcRCPT", 1'b0);
         add_row(1'b1, 3, 1'b1, 3, "hello RC", 1'b0);
         add_row(1'b0, 0, 1'b0, 2, " TO:", 1'b1);
         add_row(1'b0, 0, 1'b0, 3, "PT TO:", 1'b1);
         // Repeated starts and near misses
         add_row(1'b1, 4, 1'b1, 4, "RRCPT TO:", 1'b1);
         add_row(1'b0, 0, 1'b0, 4, "RCPRCPT TO:", 1'b1);
         add_row(1'b0, 0, 1'b0, 4, "RCPT TO;", 1'b0);
         add_row(1'b0, 0, 1'b0, 4, "RCPT  TO:", 1'b0);
         add_row(1'b0, 0, 1'b0, 4, "rcpt to:", 1'b0);
         // Disabled stream keeps no partial match
         add_row(1'b1, 5, 1'b0, 5, "xxRCPT", 1'b0);
         add_row(1'b0, 0, 1'b0, 5, " TO:", 1'b0);
         add_row(1'b1, 5, 1'b1, 5, " TO:", 1'b0);
         // Unseen stream after a stream left mid-match
         add_row(1'b1, 6, 1'b1, 6, "RCPT TO", 1'b0);
         add_row(1'b1, 7, 1'b1, 7, ":", 1'b0);
         add_row(1'b0, 0, 1'b0, 6, ":", 1'b1);
         // Disable again and then use the top stream number
         add_row(1'b1, 1, 1'b0, 1, "RCPT TO:", 1'b1);
         add_row(1'b1, 63, 1'b1, 63, "RCPT TO:", 1'b1);
      end
   endtask

   task automatic check_reset_state();
      begin
         if (count !== count_t'(0))
         begin
            $display("Mismatch after reset: count got %h expected %h", count, count_t'(0));
            error_count++;
         end
         if (fired !== 1'b0)
         begin
            $display("Mismatch after reset: fired got %h expected %h", fired, 1'b0);
            error_count++;
         end
         // Walk the enable selector over every stream
         for (int s = 0; s < NUM_STREAMS; s++)
         begin
            @(negedge clk);
            stream_id = stream_id_t'(s);
            #(CLK_PERIOD/4);
            if (smtp_scan_top_i.stream_enable !== 1'b0)
            begin
               $display("Mismatch after reset: stream_enable of stream %0d got %h expected %h",
                        s, smtp_scan_top_i.stream_enable, 1'b0);
               error_count++;
            end
         end
         tests_run++;
         $display("Reset check: %s", (error_count == 0) ? "pass" : "fail");
      end
   endtask

   task automatic run_row(input int row);
      int         errors_before;
      int         st;
      logic       matched;
      logic       got_fired;
      stream_id_t s;
      begin
         errors_before = error_count;
         s = row_stream[row];

         // Optional enable write ahead of the packet
         if (row_cfg_wr[row])
         begin
            @(negedge clk);
            cfg_wr     = 1'b1;
            cfg_stream = row_cfg_stream[row];
            cfg_enable = row_cfg_enable[row];
            model_enable[row_cfg_stream[row]] = row_cfg_enable[row];
         end

         // Packet start followed by two idle cycles
         @(negedge clk);
         cfg_wr     = 1'b0;
         stream_id  = s;
         load_state = 1'b1;
         @(negedge clk);
         load_state = 1'b0;
         @(negedge clk);

         // Model starts from the saved state or from idle
         if (model_seen[s])
            st = model_state[s];
         else
            st = 0;
         matched = 1'b0;

         for (int i = 0; i < row_len[row]; i++)
         begin
            // Occasional idle gap between bytes
            if (i > 0 && ($urandom % 4) == 0)
            begin
               @(negedge clk);
               char_in_vld = 1'b0;
            end
            @(negedge clk);
            char_in     = row_payload[row][i];
            char_in_vld = 1'b1;
            st = next_match_state(st, row_payload[row][i]);
            if (st == PATTERN_LEN)
            begin
               matched = 1'b1;
               st = 0;
            end
         end

         // Two idle cycles before eop
         @(negedge clk);
         char_in_vld = 1'b0;
         @(negedge clk);
         @(negedge clk);
         got_fired = fired;
         eop = 1'b1;
         @(negedge clk);
         eop = 1'b0;

         // Commit in the model for enabled streams only
         if (model_enable[s])
         begin
            model_count    = model_count + int'(matched);
            model_state[s] = st;
            model_seen[s]  = 1'b1;
         end

         if (matched !== row_fired[row])
         begin
            $display("Row %0d table expects fired %0b but the reference model gives %0b",
                     row, row_fired[row], matched);
            error_count++;
         end
         if (got_fired !== row_fired[row])
         begin
            $display("Mismatch row %0d: fired got %h expected %h", row, got_fired, row_fired[row]);
            error_count++;
         end
         if (count !== count_t'(model_count))
         begin
            $display("Mismatch row %0d: count got %h expected %h",
                     row, count, count_t'(model_count));
            error_count++;
         end

         tests_run++;
         $display("Row %0d stream %0d: %s", row, s,
                  (error_count == errors_before) ? "pass" : "fail");
      end
   endtask

   // Main sequence
   initial
   begin
      load_state  = 1'b0;
      stream_id   = '0;
      eop         = 1'b0;
      char_in     = '0;
      char_in_vld = 1'b0;
      cfg_wr      = 1'b0;
      cfg_stream  = '0;
      cfg_enable  = 1'b0;
      rst_n       = 1'b0;
      void'($urandom(32'h8018_fd67));

      error_count = 0;
      tests_run   = 0;
      model_count = 0;
      for (int s = 0; s < NUM_STREAMS; s++)
      begin
         model_state[s]  = 0;
         model_seen[s]   = 1'b0;
         model_enable[s] = 1'b0;
      end
      build_table();

      // Reset for three cycles and release on a falling edge
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      check_reset_state();

      for (int row = 0; row < num_rows; row++)
         run_row(row);

      @(negedge clk);
      $display("Tests run: %0d, errors: %0d", tests_run, error_count);
      if (error_count == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

   // Watchdog allows 40 cycles per row plus room for reset and the enable walk
   initial
   begin
      wait (num_rows > 0);
      #((num_rows + 4) * 40 * CLK_PERIOD);
      $display("Timeout: the table did not complete in the expected time");
      $display("ERRORS FOUND");
      $finish;
   end

endmodule

`default_nettype wire

//--- smtp_scan_assertions.sv
`default_nettype none
`timescale 1ns/10ps

module smtp_scan_assertions
   import scan_pkg::*;
(
   input wire              clk,
   input wire              rst_n,
   input wire              load_state,
   input wire              eop,
   input wire              state_in_vld,
   input wire              accept_out,
   input wire count_t      count
);

   // Matcher pulse lasts one cycle only
   accept_single: assert property (
      @(posedge clk) disable iff (!rst_n)
      accept_out |=> !accept_out
   )
   else
      $error("accept_out high for two cycles in a row");

   // Load strobe to the matcher comes one cycle after packet start
   load_to_vld: assert property (
      @(posedge clk) disable iff (!rst_n)
      load_state |=> state_in_vld
   )
   else
      $error("state_in_vld missing one cycle after load_state");

   // And never without a packet start before it
   vld_from_load: assert property (
      @(posedge clk) disable iff (!rst_n)
      state_in_vld |-> $past(load_state)
   )
   else
      $error("state_in_vld without load_state in the cycle before");

   // Counter moves only on the edge that sampled eop
   count_after_eop: assert property (
      @(posedge clk) disable iff (!rst_n)
      !$stable(count) |-> $past(eop)
   )
   else
      $error("count changed without eop in the cycle before");

endmodule

// Attach to every context block
bind stream_context smtp_scan_assertions smtp_scan_assertions_i
(
   .clk          (clk),
   .rst_n        (rst_n),
   .load_state   (load_state),
   .eop          (eop),
   .state_in_vld (state_in_vld),
   .accept_out   (accept_out),
   .count        (count)
);

`default_nettype wire

//--- smtp_scan_top.sv
`default_nettype none
`timescale 1ns/10ps

module smtp_scan_top
   import scan_pkg::*;
(
   input  wire              clk,
   input  wire              rst_n,
   // Packet framing
   input  wire              load_state,
   input  wire stream_id_t  stream_id,
   input  wire              eop,
   // Payload bytes
   input  wire byte_t       char_in,
   input  wire              char_in_vld,
   // Enable table writes
   input  wire              cfg_wr,
   input  wire stream_id_t  cfg_stream,
   input  wire              cfg_enable,
   // Results
   output logic             fired,
   output count_t           count
);

   // Enable bit of the stream in flight
   logic stream_enable;

   // Per-stream enable table
   scan_config scan_config_i
   (
      .clk           (clk),
      .rst_n         (rst_n),
      .cfg_wr        (cfg_wr),
      .cfg_stream    (cfg_stream),
      .cfg_enable    (cfg_enable),
      .stream_id     (stream_id),
      .stream_enable (stream_enable)
   );

   // State save and restore, match flag and counter
   stream_context stream_context_i
   (
      .clk           (clk),
      .rst_n         (rst_n),
      .load_state    (load_state),
      .eop           (eop),
      .stream_id     (stream_id),
      .char_in       (char_in),
      .char_in_vld   (char_in_vld),
      .stream_enable (stream_enable),
      .fired         (fired),
      .count         (count)
   );

endmodule

`default_nettype wire

//--- stream_context.sv
`default_nettype none
`timescale 1ns/10ps

module stream_context
   import scan_pkg::*;
(
   input  wire              clk,
   input  wire              rst_n,
   input  wire              load_state,
   input  wire              eop,
   input  wire stream_id_t  stream_id,
   input  wire byte_t       char_in,
   input  wire              char_in_vld,
   input  wire              stream_enable,
   output logic             fired,
   output count_t           count
);

   // Saved matcher state, one entry per stream
   dfa_state_t             state_mem [NUM_STREAMS];

   // Streams whose memory entry holds a saved state
   logic [NUM_STREAMS-1:0] seen;

   // State handed to the matcher at packet start
   dfa_state_t             state_in;
   logic                   state_in_vld;

   // Matcher results
   dfa_state_t             state_out;
   logic                   accept_out;

   // Set once the current packet has matched
   logic                   match_flag;

   // Commit point for an enabled stream
   logic                   save_state;

   assign save_state = eop && stream_enable;

   // Match flag drives the output directly
   assign fired = match_flag;

   // Load strobe to the matcher one cycle after load_state
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         state_in_vld <= 1'b0;
      else
         state_in_vld <= load_state;
   end

   // State restore at packet start
   // Unseen streams begin from idle
   always_ff @(posedge clk)
   begin
      if (load_state)
      begin
         if (seen[stream_id])
            state_in <= state_mem[stream_id];
         else
            state_in <= S_IDLE;
      end
   end

   // State save at the end of an enabled packet
   always_ff @(posedge clk)
   begin
      if (save_state)
         state_mem[stream_id] <= state_out;
   end

   // Seen bitmap
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         seen <= '0;
      else if (save_state)
         seen[stream_id] <= 1'b1;
   end

   // Per-packet match flag and match counter
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         match_flag <= 1'b0;
         count      <= '0;
      end
      else
      begin
         // New packet starts unmatched
         if (load_state)
            match_flag <= 1'b0;

         // Flag follows the matcher pulse by one edge
         if (accept_out)
            match_flag <= 1'b1;

         if (eop)
         begin
            if (stream_enable)
               // Several matches in one packet still count once
               count <= count + count_t'(match_flag);
            else
               match_flag <= 1'b0;
         end
      end
   end

   // Byte-serial matcher
   rcpt_dfa rcpt_dfa_i
   (
      .clk          (clk),
      .rst_n        (rst_n),
      .char_in      (char_in),
      .char_in_vld  (char_in_vld),
      .state_in     (state_in),
      .state_in_vld (state_in_vld),
      .state_out    (state_out),
      .accept_out   (accept_out)
   );

endmodule

`default_nettype wire

//--- scan_config.sv
`default_nettype none
`timescale 1ns/10ps

module scan_config
   import scan_pkg::*;
(
   input  wire              clk,
   input  wire              rst_n,
   // Configuration write port
   input  wire              cfg_wr,
   input  wire stream_id_t  cfg_stream,
   input  wire              cfg_enable,
   // Stream of the packet in flight
   input  wire stream_id_t  stream_id,
   output logic             stream_enable
);

   // One enable bit per stream
   logic [NUM_STREAMS-1:0] enable_q;

   // Single-bit writes
   // All streams start disabled
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         enable_q <= '0;
      else if (cfg_wr)
         enable_q[cfg_stream] <= cfg_enable;
   end

   // Select the bit of the active stream
   always_comb
   begin
      stream_enable = enable_q[stream_id];
   end

endmodule

`default_nettype wire

//--- rcpt_dfa.sv
`default_nettype none
`timescale 1ns/10ps

module rcpt_dfa
   import scan_pkg::*;
(
   input  wire              clk,
   input  wire              rst_n,
   input  wire byte_t       char_in,
   input  wire              char_in_vld,
   input  wire dfa_state_t  state_in,
   input  wire              state_in_vld,
   output dfa_state_t       state_out,
   output logic             accept_out
);

   // Character the current state waits for
   byte_t      expect_char;
   // Byte matches the expected character
   logic       char_hit;
   // Current state is the last one before a full match
   logic       last_char;
   // State taken if a byte is consumed this cycle
   dfa_state_t next_state;

   // Pattern lookup and transition table
   always_comb
   begin
      expect_char = PATTERN[8*(PATTERN_LEN-1-int'(state_out)) +: 8];
      char_hit    = (char_in == expect_char);
      last_char   = (int'(state_out) == PATTERN_LEN-1);

      if (char_hit && last_char)
         // Full pattern seen, start over
         next_state = S_IDLE;
      else if (char_hit)
         // Advance by one character
         next_state = dfa_state_t'(state_out + 4'd1);
      else if (char_in == PATTERN[8*(PATTERN_LEN-1) +: 8])
         // A mismatching R still opens a new attempt
         next_state = S_R;
      else
         next_state = S_IDLE;
   end

   // State register
   // A load from the context block wins over a byte in the same cycle
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state_out  <= S_IDLE;
         accept_out <= 1'b0;
      end
      else if (state_in_vld)
      begin
         state_out  <= state_in;
         accept_out <= 1'b0;
      end
      else if (char_in_vld)
      begin
         state_out  <= next_state;
         // One-cycle pulse on completing the pattern
         accept_out <= char_hit && last_char;
      end
      else
      begin
         accept_out <= 1'b0;
      end
   end

endmodule

`default_nettype wire

//--- scan_pkg.sv
`default_nettype none

package scan_pkg;

   // Number of interleaved TCP streams tracked
   localparam int NUM_STREAMS = 64;

   // Length of the command text searched for
   localparam int PATTERN_LEN = 8;

   // Command text
   // First character in the top byte
   localparam logic [8*PATTERN_LEN-1:0] PATTERN = "RCPT TO:";

   // One payload character
   typedef logic [7:0] byte_t;

   // Stream number
   // Wide enough for every stream
   typedef logic [$clog2(NUM_STREAMS)-1:0] stream_id_t;

   // Count of enabled packets that matched
   typedef logic [15:0] count_t;

   // Matcher states
   // Each state is the number of leading pattern characters seen so far
   typedef enum logic [3:0]
   {
      S_IDLE = 4'd0,
      S_R    = 4'd1,
      S_RC   = 4'd2,
      S_RCP  = 4'd3,
      S_RCPT = 4'd4,
      S_SP   = 4'd5,
      S_T    = 4'd6,
      S_TO   = 4'd7
   } dfa_state_t;

endpackage

`default_nettype wire
